/* hw/mac_defs.svh */
// MAC lane sizes
// element format, product and sum widths, credit count and alignment clamp
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

`define MAC_LANES        8    // element pairs per beat
`define MAC_W_ELEM       9
`define MAC_W_FEXP       4    // fp8 exponent field
`define MAC_W_MANT       4    // fp8 mantissa field, hidden 16 on top
`define MAC_W_EXP        5    // product exponent, 0..30
`define MAC_W_PROD       19
`define MAC_W_SUM        24

// output slots owned by the lane after reset
`define MAC_OUT_CREDITS  4

`define MAC_MAX_SHIFT    18   // past this a product is only sign
`define MAC_PIPE_DEPTH   3

`endif

/* hw/mac_pkg.sv */
// MAC lane package
// datatype selector carried with every input beat

package mac_pkg;

////////////////////////////////////////////////////////////
// element datatypes
////////////////////////////////////////////////////////////

// i9  : signed 9-bit integer
// fp8 : sign, 4-bit exponent, 4-bit mantissa with hidden 16
typedef enum logic [0:0] {
    DT_I9  = 1'b0,
    DT_FP8 = 1'b1
} mac_dtype_e;

endpackage

/* hw/mac_pipe_ctrl.sv */
// MAC lane pipeline control
// output credit counter, input credit grants and per-stage valid bits
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_pipe_ctrl (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_in_valid,
    input  logic                          i_ofm_credit,
    output logic                          o_in_credit,
    output logic [`MAC_PIPE_DEPTH-1:0]    o_stage_en
);

localparam int W_CNT = 3;

////////////////////////////////////////////////////////////
// credits
////////////////////////////////////////////////////////////

// every input credit spends one output slot, so a granted beat
// can never be blocked on its way out of the lane
logic [W_CNT-1:0] credit_cnt;
logic [W_CNT-1:0] credit_avail;
logic             grant;

assign credit_avail = credit_cnt + W_CNT'(i_ofm_credit); // returns count same cycle
assign grant        = (credit_avail != '0);

always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
        credit_cnt  <= W_CNT'(`MAC_OUT_CREDITS);
        o_in_credit <= 1'b0;
    end else begin
        credit_cnt  <= credit_avail - W_CNT'(grant);
        o_in_credit <= grant;     // one beat granted per pulse
    end
end

////////////////////////////////////////////////////////////
// stage valids
////////////////////////////////////////////////////////////

// bit n set while stage n holds a beat
// bit n loads stage n+1, the last bit marks a finished result
always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
        o_stage_en <= '0;
    end else begin
        o_stage_en <= {o_stage_en[`MAC_PIPE_DEPTH-2:0], i_in_valid};
    end
end

endmodule

/* hw/mac_mult_stage.sv */
// MAC multiply stage
// decodes i9 / fp8 element pairs, masks dead lanes, registers products
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_mult_stage (
    input  logic                                     i_clk,
    input  logic                                     i_reset,
    input  logic                                     i_en,
    input  mac_pkg::mac_dtype_e                      i_dtype,
    input  logic [`MAC_LANES*`MAC_W_ELEM-1:0]        i_ifm,
    input  logic [`MAC_LANES*`MAC_W_ELEM-1:0]        i_wfm,
    input  logic [`MAC_LANES-1:0]                    i_elem_valid,
    output logic [`MAC_LANES-1:0][`MAC_W_PROD-1:0]   o_prod,
    output logic [`MAC_LANES-1:0][`MAC_W_EXP-1:0]    o_exp,
    output logic [`MAC_LANES-1:0]                    o_live,
    output mac_pkg::mac_dtype_e                      o_dtype
);

localparam int W_ELEM = `MAC_W_ELEM;
localparam int W_MANT = `MAC_W_MANT;
localparam int W_PROD = `MAC_W_PROD;

logic                                   is_fp;
logic [`MAC_LANES-1:0][W_PROD-1:0]      prod_d;
logic [`MAC_LANES-1:0][`MAC_W_EXP-1:0]  exp_d;
logic [`MAC_LANES-1:0]                  live_d;

assign is_fp = (i_dtype == mac_pkg::DT_FP8);

for (genvar i = 0; i < `MAC_LANES; i++) begin : g_lane
    logic [W_ELEM-1:0]             a;
    logic [W_ELEM-1:0]             b;
    logic                          a_zero;
    logic                          b_zero;
    logic signed [2*W_ELEM-1:0]    int_prod;
    logic signed [W_PROD-1:0]      int_ext;
    logic [2*W_MANT+1:0]           fp_mag;
    logic signed [W_PROD-1:0]      fp_ext;
    logic signed [W_PROD-1:0]      fp_prod;

    assign a = i_ifm[i*W_ELEM +: W_ELEM];
    assign b = i_wfm[i*W_ELEM +: W_ELEM];

    // fp8 zero ignores the sign bit
    assign a_zero = is_fp ? (a[W_ELEM-2:0] == '0) : (a == '0);
    assign b_zero = is_fp ? (b[W_ELEM-2:0] == '0) : (b == '0);

    assign int_prod = $signed(a) * $signed(b);
    assign int_ext  = int_prod;
    assign fp_mag   = {1'b1, a[W_MANT-1:0]} * {1'b1, b[W_MANT-1:0]}; // (16+ma)(16+mb)
    assign fp_ext   = fp_mag;
    assign fp_prod  = (a[W_ELEM-1] ^ b[W_ELEM-1]) ? -fp_ext : fp_ext;

    assign live_d[i] = i_elem_valid[i] & ~a_zero & ~b_zero;
    assign prod_d[i] = !live_d[i] ? '0 : (is_fp ? fp_prod : int_ext);
    assign exp_d[i]  = (live_d[i] && is_fp) ?
                       {1'b0, a[W_MANT +: `MAC_W_FEXP]} + {1'b0, b[W_MANT +: `MAC_W_FEXP]} :
                       '0;
end

always_ff @(posedge i_clk) begin
    if (i_en) begin
        o_prod <= prod_d;
        o_exp  <= exp_d;
    end
end

always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
        o_live  <= '0;
        o_dtype <= mac_pkg::DT_I9;
    end else if (i_en) begin
        o_live  <= live_d;
        o_dtype <= i_dtype;
    end
end

endmodule

/* hw/mac_align_stage.sv */
// MAC align stage
// finds the largest live exponent and shifts every product down to it
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_align_stage (
    input  logic                                     i_clk,
    input  logic                                     i_reset,
    input  logic                                     i_en,
    input  logic [`MAC_LANES-1:0][`MAC_W_PROD-1:0]   i_prod,
    input  logic [`MAC_LANES-1:0][`MAC_W_EXP-1:0]    i_exp,
    input  logic [`MAC_LANES-1:0]                    i_live,
    input  mac_pkg::mac_dtype_e                      i_dtype,
    output logic [`MAC_LANES-1:0][`MAC_W_PROD-1:0]   o_aligned,
    output logic [`MAC_W_EXP-1:0]                    o_max_exp
);

localparam int W_PROD = `MAC_W_PROD;
localparam int W_EXP  = `MAC_W_EXP;

logic [W_EXP-1:0]                   max_exp;
logic [`MAC_LANES-1:0][W_PROD-1:0]  aligned_d;

////////////////////////////////////////////////////////////
// max exponent
////////////////////////////////////////////////////////////

// stays 0 when nothing is live
always_comb begin
    max_exp = '0;
    for (int i = 0; i < `MAC_LANES; i++) begin
        if (i_live[i] && (i_exp[i] > max_exp)) begin
            max_exp = i_exp[i];
        end
    end
end

////////////////////////////////////////////////////////////
// alignment shift
////////////////////////////////////////////////////////////

for (genvar i = 0; i < `MAC_LANES; i++) begin : g_lane
    logic [W_EXP-1:0]          diff;
    logic [W_EXP-1:0]          shift;
    logic signed [W_PROD-1:0]  prod_s;
    logic signed [W_PROD-1:0]  shifted;

    assign diff  = max_exp - i_exp[i];
    // integers all sit at exponent 0 already
    assign shift = (i_dtype == mac_pkg::DT_I9) ? '0 :
                   (diff > W_EXP'(`MAC_MAX_SHIFT)) ? W_EXP'(`MAC_MAX_SHIFT) : diff;

    assign prod_s       = i_prod[i];
    assign shifted      = prod_s >>> shift; // floors toward -inf
    assign aligned_d[i] = i_live[i] ? shifted : '0;
end

always_ff @(posedge i_clk) begin
    if (i_en) begin
        o_aligned <= aligned_d;
    end
end

always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
        o_max_exp <= '0;
    end else if (i_en) begin
        o_max_exp <= max_exp;
    end
end

endmodule

/* hw/mac_reduce_stage.sv */
// MAC reduce stage
// balanced adder tree over the aligned products, result register
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_reduce_stage (
    input  logic                                     i_clk,
    input  logic                                     i_reset,
    input  logic                                     i_en,
    input  logic [`MAC_LANES-1:0][`MAC_W_PROD-1:0]   i_aligned,
    input  logic [`MAC_W_EXP-1:0]                    i_max_exp,
    output logic signed [`MAC_W_SUM-1:0]             o_sum,
    output logic [`MAC_W_EXP-1:0]                    o_exp
);

localparam int LANES = `MAC_LANES;

////////////////////////////////////////////////////////////
// adder tree
////////////////////////////////////////////////////////////

// heap layout, leaves at LANES-1.., root at 0
logic signed [`MAC_W_SUM-1:0] node [2*LANES-1];

for (genvar i = 0; i < LANES; i++) begin : g_leaf
    logic signed [`MAC_W_PROD-1:0] leaf;

    assign leaf            = i_aligned[i];
    assign node[LANES-1+i] = leaf;    // sign extend to sum width
end

for (genvar j = 0; j < LANES-1; j++) begin : g_add
    assign node[j] = node[2*j+1] + node[2*j+2];
end

always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
        o_sum <= '0;
        o_exp <= '0;
    end else if (i_en) begin
        o_sum <= node[0];
        o_exp <= i_max_exp;  // scale of the sum
    end
end

endmodule

/* hw/mac_lane.sv */
// MAC lane top
// credit control plus multiply, align and reduce stages
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_lane (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_in_valid,
    input  mac_pkg::mac_dtype_e                   i_dtype,
    input  logic [`MAC_LANES*`MAC_W_ELEM-1:0]     i_ifm,
    input  logic [`MAC_LANES*`MAC_W_ELEM-1:0]     i_wfm,
    input  logic [`MAC_LANES-1:0]                 i_elem_valid,
    output logic                                  o_in_credit,
    input  logic                                  i_ofm_credit,
    output logic                                  o_ofm_valid,
    output logic signed [`MAC_W_SUM-1:0]          o_sum,
    output logic [`MAC_W_EXP-1:0]                 o_exp
);

logic [`MAC_PIPE_DEPTH-1:0]                 stage_en;
logic [`MAC_LANES-1:0][`MAC_W_PROD-1:0]     mult_prod;
logic [`MAC_LANES-1:0][`MAC_W_EXP-1:0]      mult_exp;
logic [`MAC_LANES-1:0]                      mult_live;
mac_pkg::mac_dtype_e                        mult_dtype;
logic [`MAC_LANES-1:0][`MAC_W_PROD-1:0]     align_data;
logic [`MAC_W_EXP-1:0]                      align_max_exp;

mac_pipe_ctrl u_pipe_ctrl (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_in_valid     (i_in_valid),
    .i_ofm_credit   (i_ofm_credit),
    .o_in_credit    (o_in_credit),
    .o_stage_en     (stage_en)
);

// first stage takes the beat straight off the input
mac_mult_stage u_mult (
    .i_clk (i_clk), .i_reset (i_reset), .i_en (i_in_valid),
    .i_dtype (i_dtype), .i_ifm (i_ifm), .i_wfm (i_wfm), .i_elem_valid (i_elem_valid),
    .o_prod (mult_prod), .o_exp (mult_exp), .o_live (mult_live), .o_dtype (mult_dtype)
);

mac_align_stage u_align (
    .i_clk (i_clk), .i_reset (i_reset), .i_en (stage_en[0]),
    .i_prod (mult_prod), .i_exp (mult_exp), .i_live (mult_live), .i_dtype (mult_dtype),
    .o_aligned (align_data), .o_max_exp (align_max_exp)
);

mac_reduce_stage u_reduce (
    .i_clk (i_clk), .i_reset (i_reset), .i_en (stage_en[1]),
    .i_aligned (align_data), .i_max_exp (align_max_exp),
    .o_sum (o_sum), .o_exp (o_exp)
);

assign o_ofm_valid = stage_en[`MAC_PIPE_DEPTH-1]; // result register is full

endmodule

/* tests/tb_mac_model.svh */
// MAC lane reference model
// element decode, pair product, alignment and beat sum from the format rules
`ifndef TB_MAC_MODEL_SVH
`define TB_MAC_MODEL_SVH

`include "mac_defs.svh"

function automatic bit elem_zero(mac_pkg::mac_dtype_e dt, logic [8:0] v);
    if (dt == mac_pkg::DT_FP8) begin
        return (v[7:0] == 8'd0);  // sign bit ignored
    end
    return (v == 9'd0);
endfunction

// fp8 value is (-1)^s * (16+m) * 2^e, so a pair carries (16+ma)(16+mb) at ea+eb
function automatic int pair_product(mac_pkg::mac_dtype_e dt, logic [8:0] a, logic [8:0] b);
    int mag;
    if (dt == mac_pkg::DT_I9) begin
        return int'({{23{a[8]}}, a}) * int'({{23{b[8]}}, b});
    end
    mag = (16 + int'(a[3:0])) * (16 + int'(b[3:0]));
    return (a[8] ^ b[8]) ? -mag : mag;
endfunction

function automatic int pair_exponent(mac_pkg::mac_dtype_e dt, logic [8:0] a, logic [8:0] b);
    return (dt == mac_pkg::DT_FP8) ? int'(a[7:4]) + int'(b[7:4]) : 0;
endfunction

task automatic model_beat(input mac_pkg::mac_dtype_e dt, input logic [71:0] ifm,
                          input logic [71:0] wfm, input logic [7:0] mask,
                          output int sum, output int max_e);
    logic [8:0] a;
    logic [8:0] b;
    bit         live [`MAC_LANES];
    int         prod [`MAC_LANES];
    int         ex [`MAC_LANES];
    int         sh;
    sum   = 0;
    max_e = 0;
    for (int i = 0; i < `MAC_LANES; i++) begin
        a       = ifm[i*`MAC_W_ELEM +: `MAC_W_ELEM];
        b       = wfm[i*`MAC_W_ELEM +: `MAC_W_ELEM];
        live[i] = mask[i] && !elem_zero(dt, a) && !elem_zero(dt, b);
        prod[i] = live[i] ? pair_product(dt, a, b) : 0;
        ex[i]   = live[i] ? pair_exponent(dt, a, b) : 0;
        if (ex[i] > max_e) begin
            max_e = ex[i];
        end
    end
    for (int i = 0; i < `MAC_LANES; i++) begin
        sh = (max_e - ex[i] > `MAC_MAX_SHIFT) ? `MAC_MAX_SHIFT : max_e - ex[i];
        sum += live[i] ? (prod[i] >>> sh) : 0;  // floor toward -inf
    end
endtask

`endif

/* tests/tb_mac_lane.sv */
// MAC lane testbench
// random i9 / fp8 beats under credit flow control, checked against a model
`timescale 1ns/1ps
`include "mac_defs.svh"

module tb_mac_lane;

localparam int CLK_PERIOD   = 20;
localparam int RESET_CYCLES = 8;
localparam int NUM_BEATS    = 400;
localparam int IDLE_CYCLES  = 12;
localparam int TIMEOUT_NS   = NUM_BEATS * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

logic                              i_clk, i_reset, i_in_valid, i_ofm_credit;
logic                              o_in_credit, o_ofm_valid;
mac_pkg::mac_dtype_e               i_dtype;
logic [`MAC_LANES*`MAC_W_ELEM-1:0] i_ifm, i_wfm;
logic [`MAC_LANES-1:0]             i_elem_valid;
logic signed [`MAC_W_SUM-1:0]      o_sum;
logic [`MAC_W_EXP-1:0]             o_exp;

logic [31:0] rng_state;
int errors, checks, cycle, held, granted, returned, pending_ret, sent;
int q_sum[$], q_exp[$], q_cyc[$];   // expected results in input order

`include "tb_mac_model.svh"

mac_lane UUT (
    .i_clk (i_clk), .i_reset (i_reset), .i_in_valid (i_in_valid), .i_dtype (i_dtype),
    .i_ifm (i_ifm), .i_wfm (i_wfm), .i_elem_valid (i_elem_valid),
    .o_in_credit (o_in_credit), .i_ofm_credit (i_ofm_credit),
    .o_ofm_valid (o_ofm_valid), .o_sum (o_sum), .o_exp (o_exp)
);

initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD/2) i_clk = ~i_clk;
end

function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

task automatic make_beat();
    logic [31:0]            r;
    logic [`MAC_W_ELEM-1:0] a, b, keep;
    r            = next_rand();
    i_dtype      = r[0] ? mac_pkg::DT_FP8 : mac_pkg::DT_I9;
    i_elem_valid = (r[7:4] == 4'd0) ? '0 : r[15:8];  // now and then all invalid
    keep         = (i_dtype == mac_pkg::DT_FP8) ? 9'h100 : 9'h000;
    for (int i = 0; i < `MAC_LANES; i++) begin
        r = next_rand();
        a = r[8:0];
        b = r[24:16];
        if (r[31:30] == 2'b00) begin  // zero element, one lane in four
            if (r[29]) a = a & keep;
            else b = b & keep;
        end
        i_ifm[i*`MAC_W_ELEM +: `MAC_W_ELEM] = a;
        i_wfm[i*`MAC_W_ELEM +: `MAC_W_ELEM] = b;
    end
endtask

task automatic check_result();
    int e_sum, e_exp, e_cyc;
    assert (q_sum.size() != 0) else begin
        errors++;
        $display("result valid at %0t with no beat in flight", $time);
    end
    if (q_sum.size() != 0) begin
        e_sum = q_sum.pop_front();
        e_exp = q_exp.pop_front();
        e_cyc = q_cyc.pop_front();
        checks++;
        assert ($signed(o_sum) == e_sum) else begin
            errors++;
            $display("FAIL %0t: sum %0d, expected %0d", $time, o_sum, e_sum);
        end
        assert (o_exp == e_exp) else begin
            errors++;
            $display("FAIL %0t: exponent %0d, expected %0d", $time, o_exp, e_exp);
        end
        assert (cycle == e_cyc) else begin
            errors++;
            $display("FAIL %0t: result in cycle %0d, expected %0d", $time, cycle, e_cyc);
        end
    end
endtask

// one falling edge: read grants and results, then drive credits and beats
task automatic step_cycle();
    logic [31:0] r;
    int          e_sum, e_exp;
    r = next_rand();
    if (o_ofm_valid) check_result();
    if (o_in_credit) begin
        held++;
        granted++;
    end
    assert (granted <= `MAC_OUT_CREDITS + returned) else begin
        errors++;
        $display("FAIL %0t: %0d credits granted, %0d returned", $time, granted, returned);
    end
    i_ofm_credit = 1'b0;
    if (pending_ret > 0 && r[0]) begin
        i_ofm_credit = 1'b1;
        pending_ret--;
        returned++;
    end
    if (o_ofm_valid) pending_ret++;  // handed back on a later cycle
    i_in_valid = 1'b0;
    if (held > 0 && sent < NUM_BEATS && r[1]) begin
        make_beat();
        model_beat(i_dtype, i_ifm, i_wfm, i_elem_valid, e_sum, e_exp);
        q_sum.push_back(e_sum);
        q_exp.push_back(e_exp);
        q_cyc.push_back(cycle + `MAC_PIPE_DEPTH);
        i_in_valid = 1'b1;
        held--;
        sent++;
    end
endtask

initial begin
    rng_state    = 32'h86b1e957;
    i_reset      = 1'b0;
    i_in_valid   = 1'b0;
    i_ofm_credit = 1'b0;
    i_dtype      = mac_pkg::DT_I9;
    i_ifm        = '0;
    i_wfm        = '0;
    i_elem_valid = '0;
    repeat (RESET_CYCLES) begin
        @(negedge i_clk);
        assert (!o_in_credit && !o_ofm_valid) else begin
            errors++;
            $display("FAIL %0t: credit or result active during reset", $time);
        end
    end
    i_reset = 1'b1;
    // no beats and no returns, so only the reset credits show up
    repeat (IDLE_CYCLES) begin
        @(negedge i_clk);
        cycle++;
        if (o_in_credit) begin
            held++;
            granted++;
        end
        assert (!o_ofm_valid) else begin
            errors++;
            $display("FAIL %0t: result valid with no beat sent", $time);
        end
    end
    assert (granted == `MAC_OUT_CREDITS) else begin
        errors++;
        $display("FAIL %0t: %0d credits after reset, expected %0d", $time, granted,
                 `MAC_OUT_CREDITS);
    end
    while (sent < NUM_BEATS || q_sum.size() != 0) begin
        @(negedge i_clk);
        cycle++;
        step_cycle();
    end
    $display("errors %0d, results checked %0d, beats sent %0d, credits %0d granted %0d returned",
             errors, checks, sent, granted, returned);
    if (errors == 0) begin
        $display("*** PASSED ***");
    end else begin
        $display("*** FAILED ***");
    end
    $finish;
end

// watchdog
initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d of %0d beats, %0d results outstanding, errors %0d",
             sent, NUM_BEATS, q_sum.size(), errors);
    $display("*** FAILED ***");
    $finish;
end

endmodule

/* build.f */
+incdir+hw
+incdir+tests
hw/mac_pkg.sv
hw/mac_pipe_ctrl.sv
hw/mac_mult_stage.sv
hw/mac_align_stage.sv
hw/mac_reduce_stage.sv
hw/mac_lane.sv
tests/tb_mac_lane.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the MAC lane testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_mac_lane -o tb_mac_lane

./obj_dir/tb_mac_lane | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
    exit 1
fi
